// File: project.f
+incdir+common
common/icache_pkg.sv
logic/lru_table.sv
icache/tagv_array.sv
icache/data_array.sv
icache/icache_ctrl.sv
icache/icache_top.sv
tb/clk_gen.sv
tb/mem_model.sv
tb/tb_icache.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f project.f --top-module tb_icache \
    -Mdir build -o sim_icache > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./build/sim_icache > sim.log 2>&1
status=$?
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

exit 0

// File: tb/tb_icache.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module tb_icache import icache_pkg::*; ();

    localparam logic [31:0] MEM_XOR = 32'h5a3c_96e1;

    typedef struct packed {
        logic [63:0] packet;
        logic        exc;
        logic [31:0] pc;
        logic        mem;      // a memory read is expected
        logic [31:0] mem_addr;
        logic        mem_unc;
    } exp_t;

    wire         clk;
    wire         rstn;
    icache_req_t req;
    logic        req_valid;
    wire         req_ready;
    icache_rsp_t rsp;
    wire         rsp_valid;
    logic        rsp_ready;
    mem_req_t    mem_req;
    wire         mem_valid;
    wire         mem_ready;
    line_t       mem_data;

    exp_t  exp_cur;
    string test_name;
    logic  busy;
    logic  mem_seen;
    int    low_cnt;
    int    req_issued;
    int    cycles;

    // reference state of the cache
    logic m_valid [64][2];
    tag_t m_tag   [64][2];
    logic m_mru   [64];

    clk_gen u_clk (.o_clk(clk), .o_rstn(rstn));

    mem_model u_mem (
        .clk(clk), .rstn(rstn), .i_req(mem_req), .i_valid(mem_valid),
        .o_ready(mem_ready), .o_data(mem_data)
    );

    icache_top DUT (
        .clk(clk), .rstn(rstn),
        .i_req(req), .i_req_valid(req_valid), .o_req_ready(req_ready),
        .o_rsp(rsp), .o_rsp_valid(rsp_valid), .i_rsp_ready(rsp_ready),
        .o_mem_req(mem_req), .o_mem_valid(mem_valid),
        .i_mem_ready(mem_ready), .i_mem_data(mem_data)
    );

    function automatic logic [31:0] word_at(logic [31:0] a);
        return {a[31:2], 2'b00} ^ MEM_XOR;
    endfunction

    // predicts response and memory traffic and updates the model
    function automatic exp_t predict(logic [31:0] addr, icache_op_e op, logic unc);
        exp_t        e;
        logic [5:0]  idx;
        tag_t        tag;
        logic [31:0] a8;
        logic        h0;
        logic        h1;
        logic        vw;
        idx = addr[11:6];
        tag = addr[31:12];
        a8  = {addr[31:3], 3'b000};
        h0  = m_valid[idx][0] && m_tag[idx][0] == tag;
        h1  = m_valid[idx][1] && m_tag[idx][1] == tag;
        e   = '0;
        e.pc = addr;
        if (op == OP_IDX_INV) begin
            m_valid[idx][addr[0]] = 1'b0;
        end else if (op == OP_HIT_INV) begin
            if (h0) m_valid[idx][0] = 1'b0;
            if (h1) m_valid[idx][1] = 1'b0;
        end else if (addr[1:0] != 2'b00) begin
            e.exc    = 1'b1;
            e.packet = {`ICACHE_INST_NOP, `ICACHE_INST_NOP};
        end else begin
            e.packet = {word_at(a8 + 32'd4), word_at(a8)};
            if (unc) begin
                e.mem      = 1'b1;
                e.mem_addr = a8;
                e.mem_unc  = 1'b1;
            end else if (h0 || h1) begin
                m_mru[idx] = h1;
            end else begin
                if (!m_valid[idx][0]) vw = 1'b0;
                else if (!m_valid[idx][1]) vw = 1'b1;
                else vw = !m_mru[idx];
                m_valid[idx][vw] = 1'b1;
                m_tag[idx][vw]   = tag;
                m_mru[idx]       = vw;
                e.mem      = 1'b1;
                e.mem_addr = {addr[31:6], 6'd0};
            end
        end
        return e;
    endfunction

    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_eq(string what, logic [63:0] expv, logic [63:0] actv);
        assert (expv === actv) else begin
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, expv, actv);
            stop_run();
        end
    endtask

    // comparison process
    always @(posedge clk) begin
        if (rstn && mem_valid && mem_ready) begin
            assert (busy && exp_cur.mem && !mem_seen) else begin
                $display("%s: memory read that should not happen", test_name);
                stop_run();
            end
            check_eq("mem addr", 64'(exp_cur.mem_addr), 64'(mem_req.addr));
            check_eq("mem uncached", 64'(exp_cur.mem_unc), 64'(mem_req.uncached));
            mem_seen = 1'b1;
        end
        if (rstn && rsp_valid && rsp_ready) begin
            assert (busy) else begin
                $display("response arrived with no request in flight");
                stop_run();
            end
            check_eq("mem read count", 64'(exp_cur.mem), 64'(mem_seen));
            check_eq("packet", exp_cur.packet, rsp.packet);
            check_eq("exc", 64'(exp_cur.exc), 64'(rsp.exc));
            check_eq("pc", 64'(exp_cur.pc), 64'(rsp.pc));
            busy = 1'b0;
        end
    end

    // each response stalls for 0 to 3 of its own valid cycles
    always @(posedge clk) begin
        if (!rstn) begin
            rsp_ready <= 1'b0;
            low_cnt = 0;
        end else if (rsp_valid && rsp_ready) begin
            low_cnt = $urandom_range(0, 3);
            rsp_ready <= (low_cnt == 0);
        end else if (low_cnt == 0) begin
            rsp_ready <= 1'b1;
        end else if (rsp_valid) begin
            low_cnt--;
            rsp_ready <= (low_cnt == 0);
        end
    end

    // watchdog allows 200 cycles per issued request
    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > 200 * (req_issued + 1) + 10) begin
                $display("timeout: the cache stopped responding during %s", test_name);
                stop_run();
            end
        end
    end

    task automatic run_req(string name, logic [31:0] addr, icache_op_e op, logic unc);
        test_name = name;
        exp_cur   = predict(addr, op, unc);
        mem_seen  = 1'b0;
        busy      = 1'b1;
        req_issued++;
        req_valid <= 1'b1;
        req       <= '{addr: addr, op: op, uncached: unc};
        do @(posedge clk); while (!req_ready);
        req_valid <= 1'b0;
        while (busy) @(posedge clk);
        @(posedge clk);
    endtask

    initial begin
        logic [31:0] a;
        void'($urandom(61));
        req        = '0;
        req_valid  = 1'b0;
        rsp_ready  = 1'b0;
        busy       = 1'b0;
        mem_seen   = 1'b0;
        req_issued = 0;
        test_name  = "reset";
        exp_cur    = '0;
        for (int s = 0; s < 64; s++) begin
            m_valid[s][0] = 1'b0;
            m_valid[s][1] = 1'b0;
            m_mru[s]      = 1'b0;
        end
        @(posedge rstn);
        @(posedge clk);
        check_eq("req_ready", 64'd1, 64'(req_ready));
        check_eq("rsp_valid", 64'd0, 64'(rsp_valid));
        check_eq("mem_valid", 64'd0, 64'(mem_valid));

        for (int i = 0; i < 60; i++) begin
            a = {20'h00010 + 20'($urandom_range(0, 3)), 6'($urandom_range(0, 7)),
                 4'($urandom_range(0, 15)), 2'b00};
            run_req("rand_fetch", a, OP_FETCH, 1'b0);
        end

        run_req("first_fetch", 32'h0002_0a00, OP_FETCH, 1'b0);
        run_req("refetch", 32'h0002_0a34, OP_FETCH, 1'b0);

        // A, B, A, C at one index, then A hits and B misses
        run_req("lru_a", 32'h0010_0a08, OP_FETCH, 1'b0);
        run_req("lru_b", 32'h0020_0a10, OP_FETCH, 1'b0);
        run_req("lru_a2", 32'h0010_0a18, OP_FETCH, 1'b0);
        run_req("lru_c", 32'h0030_0a20, OP_FETCH, 1'b0);
        run_req("lru_a_hit", 32'h0010_0a28, OP_FETCH, 1'b0);
        run_req("lru_b_miss", 32'h0020_0a30, OP_FETCH, 1'b0);

        run_req("uncached", 32'h0003_0b4c, OP_FETCH, 1'b1);
        run_req("uncached_then", 32'h0003_0b48, OP_FETCH, 1'b0);

        run_req("misaligned", 32'h0004_0c02, OP_FETCH, 1'b0);
        run_req("misaligned_unc", 32'h0004_0c07, OP_FETCH, 1'b1);

        run_req("idx_fill", 32'h0005_0c80, OP_FETCH, 1'b0);
        run_req("idx_inv", 32'h0005_0c80, OP_IDX_INV, 1'b0);
        run_req("idx_refetch", 32'h0005_0c88, OP_FETCH, 1'b0);

        // way 1 picked by address bit 0, way 0 stays
        run_req("idx_fill_w1", 32'h0008_0c80, OP_FETCH, 1'b0);
        run_req("idx_inv_w1", 32'h0008_0c81, OP_IDX_INV, 1'b0);
        run_req("idx_w0_kept", 32'h0005_0c90, OP_FETCH, 1'b0);
        run_req("idx_w1_refetch", 32'h0008_0c98, OP_FETCH, 1'b0);

        run_req("hit_fill", 32'h0006_0cc0, OP_FETCH, 1'b0);
        run_req("hit_inv", 32'h0006_0cc4, OP_HIT_INV, 1'b0);
        run_req("hit_refetch", 32'h0006_0cd0, OP_FETCH, 1'b0);
        run_req("hit_inv_absent", 32'h0007_0cc0, OP_HIT_INV, 1'b0);
        run_req("after_absent", 32'h0006_0cd8, OP_FETCH, 1'b0);

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module mem_model import icache_pkg::*; (
    input  wire      clk,
    input  wire      rstn,
    input  mem_req_t i_req,
    input  wire      i_valid,
    output logic     o_ready,
    output line_t    o_data
);

    localparam logic [31:0] MEM_XOR = 32'h5a3c_96e1;

    logic busy;
    int   wait_cnt;

    // word i comes from byte address addr + 4*i
    function automatic line_t make_line(logic [31:0] addr);
        line_t       l;
        logic [31:0] a;
        for (int i = 0; i < 16; i++) begin
            a    = addr + 32'(4 * i);
            l[i] = {a[31:2], 2'b00} ^ MEM_XOR;
        end
        return l;
    endfunction

    initial begin
        o_ready  = 1'b0;
        o_data   = '0;
        busy     = 1'b0;
        wait_cnt = 0;
    end

    always @(posedge clk) begin
        if (!rstn) begin
            o_ready <= 1'b0;
            busy = 1'b0;
        end else begin
            o_ready <= 1'b0;
            if (i_valid && !o_ready) begin
                if (!busy) begin
                    busy = 1'b1;
                    wait_cnt = $urandom_range(0, 5); // 1 to 6 cycles of delay
                end
                if (wait_cnt == 0) begin
                    o_ready <= 1'b1;
                    o_data  <= make_line(i_req.addr);
                    busy = 1'b0;
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic o_clk,
    output logic o_rstn
);

    initial begin
        o_clk  = 1'b0;
        o_rstn = 1'b0;
        forever #5 o_clk = ~o_clk; // 10 ns period
    end

    initial begin
        repeat (4) @(posedge o_clk);
        o_rstn <= 1'b1;
    end

endmodule

`default_nettype wire

// File: icache/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module icache_top import icache_pkg::*; (
    input  wire         clk,
    input  wire         rstn,
    input  icache_req_t i_req,
    input  wire         i_req_valid,
    output logic        o_req_ready,
    output icache_rsp_t o_rsp,
    output logic        o_rsp_valid,
    input  wire         i_rsp_ready,
    output mem_req_t    o_mem_req,
    output logic        o_mem_valid,
    input  wire         i_mem_ready,
    input  line_t       i_mem_data
);

    logic [`ICACHE_INDEX_WIDTH-1:0] rd_index;
    logic [`ICACHE_INDEX_WIDTH-1:0] wr_index;
    logic [1:0]                     wr_way;
    logic                           wr_clear;
    tag_t                           cmp_tag;
    line_t                          wr_line;
    logic                           lru_update;
    logic                           lru_way;
    logic [1:0]                     hit;
    logic [1:0]                     valid;
    line_t [1:0]                    lines;
    logic                           victim_way;

    icache_ctrl u_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .i_req        (i_req),
        .i_req_valid  (i_req_valid),
        .o_req_ready  (o_req_ready),
        .o_rsp        (o_rsp),
        .o_rsp_valid  (o_rsp_valid),
        .i_rsp_ready  (i_rsp_ready),
        .o_mem_req    (o_mem_req),
        .o_mem_valid  (o_mem_valid),
        .i_mem_ready  (i_mem_ready),
        .i_mem_data   (i_mem_data),
        .o_rd_index   (rd_index),
        .o_wr_index   (wr_index),
        .o_wr_way     (wr_way),
        .o_wr_clear   (wr_clear),
        .o_cmp_tag    (cmp_tag),
        .o_wr_line    (wr_line),
        .o_lru_update (lru_update),
        .o_lru_way    (lru_way),
        .i_hit        (hit),
        .i_lines      (lines),
        .i_victim_way (victim_way)
    );

    // fill tag is the buffered tag, same as the compare tag
    tagv_array u_tagv (
        .clk        (clk),
        .rstn       (rstn),
        .i_rd_index (rd_index),
        .i_wr_index (wr_index),
        .i_wr_way   (wr_way),
        .i_wr_clear (wr_clear),
        .i_wr_tag   (cmp_tag),
        .i_cmp_tag  (cmp_tag),
        .o_hit      (hit),
        .o_valid    (valid)
    );

    data_array u_data (
        .clk        (clk),
        .i_rd_index (rd_index),
        .i_wr_index (wr_index),
        .i_wr_way   (wr_way & {2{~wr_clear}}), // invalidates leave data alone
        .i_wr_line  (wr_line),
        .o_lines    (lines)
    );

    lru_table u_lru (
        .clk          (clk),
        .rstn         (rstn),
        .i_index      (wr_index),
        .i_valid      (valid),
        .i_update     (lru_update),
        .i_used_way   (lru_way),
        .o_victim_way (victim_way)
    );

endmodule

`default_nettype wire

// File: icache/icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module icache_ctrl import icache_pkg::*; (
    input  wire                            clk,
    input  wire                            rstn,
    input  icache_req_t                    i_req,
    input  wire                            i_req_valid,
    output logic                           o_req_ready,
    output icache_rsp_t                    o_rsp,
    output logic                           o_rsp_valid,
    input  wire                            i_rsp_ready,
    output mem_req_t                       o_mem_req,
    output logic                           o_mem_valid,
    input  wire                            i_mem_ready,
    input  line_t                          i_mem_data,
    output logic [`ICACHE_INDEX_WIDTH-1:0] o_rd_index,
    output logic [`ICACHE_INDEX_WIDTH-1:0] o_wr_index,
    output logic [1:0]                     o_wr_way,
    output logic                           o_wr_clear,
    output tag_t                           o_cmp_tag,
    output line_t                          o_wr_line,
    output logic                           o_lru_update,
    output logic                           o_lru_way,
    input  wire  [1:0]                     i_hit,
    input  line_t [1:0]                    i_lines,
    input  wire                            i_victim_way
);

    icache_state_e state, next_state;
    icache_req_t   req_q;    // request buffer
    line_t         ret_buf;  // return buffer
    logic          fill_pending;

    logic          accept;
    logic          rsp_fire;
    logic          mem_fire;
    logic          misaligned;
    logic          lookup_hit;
    logic          hit_way;
    line_t         sel_line;
    logic [`ICACHE_BYTE_OFFSET_WIDTH-4:0] pkt_sel;

    assign o_req_ready = (state == IDLE); // one request in flight
    assign accept      = i_req_valid && o_req_ready;
    assign rsp_fire    = o_rsp_valid && i_rsp_ready;
    assign mem_fire    = o_mem_valid && i_mem_ready;

    assign misaligned  = (req_q.op == OP_FETCH) && (req_q.addr[1:0] != 2'b00);
    assign hit_way     = i_hit[1];
    assign lookup_hit  = (state == LOOKUP) && !misaligned && !req_q.uncached && (|i_hit);

    // incoming index only while idle, so stalls keep the arrays steady
    assign o_rd_index = (state == IDLE) ?
                        i_req.addr[`ICACHE_BYTE_OFFSET_WIDTH +: `ICACHE_INDEX_WIDTH] :
                        req_q.addr[`ICACHE_BYTE_OFFSET_WIDTH +: `ICACHE_INDEX_WIDTH];
    assign o_wr_index = req_q.addr[`ICACHE_BYTE_OFFSET_WIDTH +: `ICACHE_INDEX_WIDTH];
    assign o_cmp_tag  = req_q.addr[31 -: `ICACHE_TAG_WIDTH];
    assign o_wr_line  = ret_buf;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state        <= IDLE;
            fill_pending <= 1'b0;
        end else begin
            state        <= next_state;
            fill_pending <= mem_fire && !req_q.uncached; // high for the first refill cycle
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= i_req;
        end
        if (mem_fire) begin
            ret_buf <= i_mem_data;
        end
    end

    always_comb begin
        next_state = state;
        unique case (state)
            IDLE: begin
                if (accept) begin
                    next_state = (i_req.op == OP_FETCH) ? LOOKUP : CACOP;
                end
            end
            LOOKUP: begin
                if (misaligned || lookup_hit) begin
                    if (rsp_fire) next_state = IDLE;
                end else begin
                    next_state = MISS; // miss or uncached
                end
            end
            MISS: begin
                if (i_mem_ready) next_state = REFILL;
            end
            REFILL, CACOP: begin
                if (rsp_fire) next_state = IDLE;
            end
            default: next_state = IDLE;
        endcase
    end

    // memory read, line aligned or one packet
    assign o_mem_valid        = (state == MISS);
    assign o_mem_req.uncached = req_q.uncached;
    assign o_mem_req.addr     = req_q.uncached ?
                                {req_q.addr[31:3], 3'b000} :
                                {req_q.addr[31:`ICACHE_BYTE_OFFSET_WIDTH],
                                 {`ICACHE_BYTE_OFFSET_WIDTH{1'b0}}};

    assign o_rsp_valid = (state == LOOKUP && (misaligned || lookup_hit)) ||
                         (state == REFILL) || (state == CACOP);

    // uncached data lands in the low packet of the line
    assign sel_line = (state == REFILL) ? ret_buf : i_lines[hit_way];
    assign pkt_sel  = req_q.uncached ? '0 : req_q.addr[`ICACHE_BYTE_OFFSET_WIDTH-1:3];

    always_comb begin
        o_rsp.pc  = req_q.addr;
        o_rsp.exc = misaligned;
        if (misaligned) begin
            o_rsp.packet = {`ICACHE_INST_NOP, `ICACHE_INST_NOP};
        end else if (state == CACOP) begin
            o_rsp.packet = '0;
        end else begin
            o_rsp.packet = sel_line[{pkt_sel, 1'b0} +: 2];
        end
    end

    // fills, invalidates and LRU touches
    always_comb begin
        o_wr_way   = 2'b00;
        o_wr_clear = (state == CACOP);
        if (fill_pending) begin
            o_wr_way = i_victim_way ? 2'b10 : 2'b01;
        end else if (state == CACOP) begin
            if (req_q.op == OP_IDX_INV) begin
                o_wr_way = req_q.addr[0] ? 2'b10 : 2'b01;
            end else if (req_q.op == OP_HIT_INV) begin
                o_wr_way = i_hit; // zero when the line is absent
            end
        end
    end

    assign o_lru_update = fill_pending || (lookup_hit && rsp_fire);
    assign o_lru_way    = fill_pending ? i_victim_way : hit_way;

endmodule

`default_nettype wire

// File: icache/data_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module data_array import icache_pkg::*; (
    input  wire                           clk,
    input  wire [`ICACHE_INDEX_WIDTH-1:0] i_rd_index,
    input  wire [`ICACHE_INDEX_WIDTH-1:0] i_wr_index,
    input  wire [1:0]                     i_wr_way,
    input  line_t                         i_wr_line,
    output line_t [1:0]                   o_lines
);

    // one line memory per way
    for (genvar w = 0; w < 2; w++) begin : g_way
        line_t line_mem [`ICACHE_SETS];

        always_ff @(posedge clk) begin
            if (i_wr_way[w]) begin
                line_mem[i_wr_index] <= i_wr_line;
            end
            o_lines[w] <= line_mem[i_rd_index]; // old data on same-index write
        end
    end

endmodule

`default_nettype wire

// File: icache/tagv_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module tagv_array import icache_pkg::*; (
    input  wire                           clk,
    input  wire                           rstn,
    input  wire [`ICACHE_INDEX_WIDTH-1:0] i_rd_index,
    input  wire [`ICACHE_INDEX_WIDTH-1:0] i_wr_index,
    input  wire [1:0]                     i_wr_way,
    input  wire                           i_wr_clear,
    input  tag_t                          i_wr_tag,
    input  tag_t                          i_cmp_tag,
    output logic [1:0]                    o_hit,
    output logic [1:0]                    o_valid
);

    for (genvar w = 0; w < 2; w++) begin : g_way
        tag_t                    tag_mem [`ICACHE_SETS];
        tag_t                    tag_q;
        logic [`ICACHE_SETS-1:0] valid_bits;
        logic                    valid_q;

        // tag storage, synchronous read
        always_ff @(posedge clk) begin
            if (i_wr_way[w] && !i_wr_clear) begin
                tag_mem[i_wr_index] <= i_wr_tag;
            end
            tag_q <= tag_mem[i_rd_index];
        end

        // valid flags live in flops so reset can clear them all at once
        always_ff @(posedge clk) begin
            if (!rstn) begin
                valid_bits <= '0;
                valid_q    <= 1'b0;
            end else begin
                if (i_wr_way[w]) begin
                    valid_bits[i_wr_index] <= !i_wr_clear; // fill sets, cacop clears
                end
                valid_q <= valid_bits[i_rd_index];
            end
        end

        assign o_valid[w] = valid_q;
        assign o_hit[w]   = valid_q && (tag_q == i_cmp_tag);
    end

endmodule

`default_nettype wire

// File: logic/lru_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module lru_table (
    input  wire                           clk,
    input  wire                           rstn,
    input  wire [`ICACHE_INDEX_WIDTH-1:0] i_index,
    input  wire [1:0]                     i_valid,
    input  wire                           i_update,
    input  wire                           i_used_way,
    output logic                          o_victim_way
);

    logic [`ICACHE_SETS-1:0] mru; // most recently used way per set

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mru <= '0;
        end else if (i_update) begin
            mru[i_index] <= i_used_way;
        end
    end

    // free way first, lowest number wins
    always_comb begin
        if (!i_valid[0]) begin
            o_victim_way = 1'b0;
        end else if (!i_valid[1]) begin
            o_victim_way = 1'b1;
        end else begin
            o_victim_way = !mru[i_index];
        end
    end

endmodule

`default_nettype wire

// File: common/icache_pkg.sv
`default_nettype none

package icache_pkg;

`include "icache_settings.svh"

    // request kind from the fetch unit
    typedef enum logic [1:0] {
        OP_FETCH   = 2'd0,
        OP_IDX_INV = 2'd1, // way picked by addr[0]
        OP_HIT_INV = 2'd2
    } icache_op_e;

    typedef struct packed {
        logic [31:0] addr;
        icache_op_e  op;
        logic        uncached;
    } icache_req_t;

    typedef struct packed {
        logic [`ICACHE_FETCH_BITS-1:0] packet; // two instructions
        logic [31:0]                   pc;
        logic                          exc;    // misaligned fetch
    } icache_rsp_t;

    typedef struct packed {
        logic [31:0] addr;
        logic        uncached; // single 8-byte read, no fill
    } mem_req_t;

    // word 0 sits in the low bits
    typedef logic [(1 << `ICACHE_WORD_OFFSET_WIDTH)-1:0][31:0] line_t;

    typedef logic [`ICACHE_TAG_WIDTH-1:0] tag_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REFILL,
        CACOP
    } icache_state_e;

endpackage

`default_nettype wire

// File: common/icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// cache geometry
`define ICACHE_INDEX_WIDTH        6
`define ICACHE_WORD_OFFSET_WIDTH  4
`define ICACHE_BYTE_OFFSET_WIDTH  (`ICACHE_WORD_OFFSET_WIDTH + 2)
`define ICACHE_TAG_WIDTH          (32 - `ICACHE_INDEX_WIDTH - `ICACHE_BYTE_OFFSET_WIDTH)
`define ICACHE_SETS               (1 << `ICACHE_INDEX_WIDTH)

// line and fetch packet widths
`define ICACHE_LINE_BITS          512
`define ICACHE_FETCH_BITS         64

// andi r0, r0, 0
`define ICACHE_INST_NOP           32'h0340_0000

`endif
